//--- lvda.f
source/lvda_pkg.sv
source/input_filter.sv
source/pio_decode.sv
source/interrupt_register.sv
source/buffer_registers.sv
source/lvda.sv
tests/lvda_tb.sv

//--- Bender.yml
package:
  name: lvda

sources:
  - source/lvda_pkg.sv
  - source/input_filter.sv
  - source/pio_decode.sv
  - source/interrupt_register.sv
  - source/buffer_registers.sv
  - source/lvda.sv
  - target: test
    files:
      - tests/lvda_tb.sv

//--- tests/lvda_tb.sv
module lvda_tb;

    logic                 sim_clk;
    logic                 rst_n;
    logic                 pio;
    lvda_pkg::pio_addr_t  pio_addr;
    lvda_pkg::word_t      pio_data;
    lvda_pkg::discrete_t  discretes_x;
    lvda_pkg::interrupt_t interrupts_x;
    lvda_pkg::word_t      brd;
    lvda_pkg::word_t      rd_data;
    logic                 rd_valid;
    logic                 intc;

    // model of what the computer should see.
    lvda_pkg::discrete_t  model_discretes;
    lvda_pkg::interrupt_t model_pending;
    lvda_pkg::word_t      model_brd;

    lvda_pkg::word_t exp_data[$];
    int unsigned     exp_cycle[$];  // cycle in which rd_valid is due.
    int unsigned     cycle;
    integer          seed;

    lvda i_dut (
        .sim_clk      (sim_clk),
        .rst_n        (rst_n),
        .pio          (pio),
        .pio_addr     (pio_addr),
        .pio_data     (pio_data),
        .discretes_x  (discretes_x),
        .interrupts_x (interrupts_x),
        .brd          (brd),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .intc         (intc)
    );

    always #50 sim_clk = ~sim_clk;

    always @(posedge sim_clk) begin
        cycle <= cycle + 1;
    end

    // expected read word for a read address.
    function automatic lvda_pkg::word_t expected_read(
        input lvda_pkg::pio_addr_t  addr,
        input lvda_pkg::discrete_t  disc,
        input lvda_pkg::interrupt_t pend,
        input lvda_pkg::word_t      brd_value
    );
        lvda_pkg::word_t result;
        result = '0;
        case (addr)
            lvda_pkg::ADDR_DISCRETES:  result[lvda_pkg::NUM_DISCRETES-1:0] = disc;
            lvda_pkg::ADDR_INTERRUPTS: result[lvda_pkg::NUM_INTERRUPTS-1:0] = pend;
            lvda_pkg::ADDR_BRD_READ:   result = brd_value;
            default:                   result = '0;
        endcase
        return result;
    endfunction

    function automatic bit is_read_addr(input lvda_pkg::pio_addr_t addr);
        return (addr == lvda_pkg::ADDR_DISCRETES) || (addr == lvda_pkg::ADDR_INTERRUPTS)
            || (addr == lvda_pkg::ADDR_BRD_READ);
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_with_failure($sformatf("MISMATCH at time %0t: %s", $time, msg));
    endtask

    // drive point, a little after the rising edge.
    task automatic next_cycle();
        @(posedge sim_clk);
        #10;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic send_strobe(input lvda_pkg::pio_addr_t addr, input lvda_pkg::word_t data);
        pio      = 1'b1;
        pio_addr = addr;
        pio_data = data;
        if (is_read_addr(addr)) begin
            exp_data.push_back(expected_read(addr, model_discretes, model_pending, model_brd));
            exp_cycle.push_back(cycle + 2);
        end
        next_cycle();
        pio = 1'b0;
    endtask

    task automatic wait_responses();
        int i;
        for (i = 0; i < 10 && exp_data.size() != 0; i++) begin
            next_cycle();
        end
        if (exp_data.size() != 0) begin
            stop_with_failure("a read response did not arrive within 10 cycles");
        end
    endtask

    task automatic wait_for_intc(input logic level, input string what);
        int i;
        for (i = 0; i < 40 && intc !== level; i++) begin
            next_cycle();
        end
        if (intc !== level) begin
            stop_with_failure(what);
        end
    endtask

    task automatic hold_discretes(input lvda_pkg::discrete_t value);
        discretes_x = value;
        wait_cycles(20);
        model_discretes = value;
    endtask

    task automatic load_brd(input lvda_pkg::word_t value);
        lvda_pkg::word_t old_value;
        old_value = model_brd;
        send_strobe(lvda_pkg::ADDR_BRD_LOAD, value);
        @(negedge sim_clk);
        assert (brd == old_value) else
            report_mismatch($sformatf("brd changed 1 cycle after load: %h", brd));
        next_cycle();
        @(negedge sim_clk);
        assert (brd == value) else
            report_mismatch($sformatf("brd is %h 2 cycles after load, expected %h", brd, value));
        model_brd = value;
        next_cycle();
    endtask

    // compares every read response against the queue.
    always @(negedge sim_clk) begin
        if (rst_n) begin
            if (rd_valid) begin
                assert (exp_data.size() != 0) else
                    report_mismatch("rd_valid pulsed with no read outstanding");
                assert (exp_cycle[0] == cycle) else
                    report_mismatch($sformatf("rd_valid in cycle %0d, expected in cycle %0d",
                        cycle, exp_cycle[0]));
                assert (rd_data == exp_data[0]) else
                    report_mismatch($sformatf("rd_data %h, expected %h", rd_data, exp_data[0]));
                void'(exp_data.pop_front());
                void'(exp_cycle.pop_front());
            end else if (exp_cycle.size() != 0) begin
                assert (exp_cycle[0] != cycle) else
                    report_mismatch($sformatf("rd_valid missing in cycle %0d", cycle));
            end
        end
    end

    initial begin
        #(100 * 20000);
        stop_with_failure("simulation did not finish within the time limit");
    end

    initial begin
        lvda_pkg::discrete_t  stable;
        lvda_pkg::interrupt_t lines;
        lvda_pkg::interrupt_t mask;
        lvda_pkg::word_t      clear_word;
        int                   i;

        seed            = 32'h70c3_f5bf;
        sim_clk         = 1'b0;
        rst_n           = 1'b0;
        pio             = 1'b0;
        pio_addr        = '0;
        pio_data        = '0;
        discretes_x     = '0;
        interrupts_x    = '0;
        cycle           = 0;
        model_discretes = '0;
        model_pending   = '0;
        model_brd       = '0;

        repeat (8) @(posedge sim_clk);
        #10;
        rst_n = 1'b1;

        // reset state.
        @(negedge sim_clk);
        assert (brd == '0) else report_mismatch($sformatf("brd is %h after reset", brd));
        assert (intc == 1'b0) else report_mismatch("intc is high after reset");
        next_cycle();
        wait_cycles(10);  // no strobes, so no rd_valid.
        send_strobe(lvda_pkg::ADDR_INTERRUPTS, '0);
        wait_responses();

        for (i = 0; i < 6; i++) begin
            hold_discretes(lvda_pkg::discrete_t'($random(seed)));
            send_strobe(lvda_pkg::ADDR_DISCRETES, '0);
            wait_responses();
        end

        // 2-cycle transient on a stable input.
        stable = lvda_pkg::discrete_t'($random(seed));
        hold_discretes(stable);
        discretes_x = stable ^ (lvda_pkg::discrete_t'($random(seed)) | 1'b1);
        for (i = 0; i < 8; i++) begin
            if (i == 2) begin
                discretes_x = stable;
            end
            send_strobe(lvda_pkg::ADDR_DISCRETES, '0);  // reads across the pulse.
        end
        wait_responses();
        wait_cycles(20);
        send_strobe(lvda_pkg::ADDR_DISCRETES, '0);
        wait_responses();

        for (i = 0; i < 4; i++) begin
            load_brd(lvda_pkg::word_t'($random(seed)));
            send_strobe(lvda_pkg::ADDR_BRD_READ, '0);
            wait_responses();
        end

        // interrupts, at least bits 0 and 2.
        lines = lvda_pkg::interrupt_t'($random(seed)) | 7'h05;
        interrupts_x = lines;
        wait_for_intc(1'b1, "intc did not rise after the interrupt lines rose");
        model_pending = model_pending | lines;
        send_strobe(lvda_pkg::ADDR_INTERRUPTS, '0);
        wait_responses();
        interrupts_x = '0;
        wait_cycles(20);
        send_strobe(lvda_pkg::ADDR_INTERRUPTS, '0);
        wait_responses();

        mask = ((lines & lvda_pkg::interrupt_t'($random(seed))) | 7'h01) & ~7'h04;
        clear_word = lvda_pkg::word_t'($random(seed));  // upper bits are ignored.
        clear_word[lvda_pkg::NUM_INTERRUPTS-1:0] = mask;
        send_strobe(lvda_pkg::ADDR_INT_RESET, clear_word);
        model_pending = model_pending & ~mask;
        send_strobe(lvda_pkg::ADDR_INTERRUPTS, '0);
        wait_responses();
        assert (intc == 1'b1) else report_mismatch("intc fell with interrupts still pending");

        send_strobe(lvda_pkg::ADDR_INT_RESET, lvda_pkg::word_t'(model_pending));
        model_pending = '0;
        wait_for_intc(1'b0, "intc did not fall after all interrupts were cleared");
        send_strobe(lvda_pkg::ADDR_INTERRUPTS, '0);
        wait_responses();

        // back-to-back strobes with an unknown address in the middle.
        load_brd(lvda_pkg::word_t'($random(seed)));
        send_strobe(lvda_pkg::ADDR_DISCRETES, '0);
        send_strobe(9'h1ff, lvda_pkg::word_t'($random(seed)));
        send_strobe(lvda_pkg::ADDR_BRD_READ, '0);
        wait_responses();
        wait_cycles(5);

        if (exp_data.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_failure("read responses still outstanding at the end of the run");
        end
    end

endmodule

//--- source/lvda.sv
module lvda (
    input  logic                 sim_clk,
    input  logic                 rst_n,
    input  logic                 pio,
    input  lvda_pkg::pio_addr_t  pio_addr,
    input  lvda_pkg::word_t      pio_data,
    input  lvda_pkg::discrete_t  discretes_x,
    input  lvda_pkg::interrupt_t interrupts_x,
    output lvda_pkg::word_t      brd,
    output lvda_pkg::word_t      rd_data,
    output logic                 rd_valid,
    output logic                 intc
);

    // decoded commands.
    logic                rd_en;
    lvda_pkg::read_src_e rd_sel;
    logic                brd_load;
    logic                int_clear;
    lvda_pkg::word_t     wr_data;

    // conditioned inputs.
    lvda_pkg::discrete_t  filt_discretes;
    lvda_pkg::interrupt_t filt_interrupts;
    lvda_pkg::interrupt_t int_pending;

    pio_decode i_pio_decode (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .pio       (pio),
        .pio_addr  (pio_addr),
        .pio_data  (pio_data),
        .rd_en     (rd_en),
        .rd_sel    (rd_sel),
        .brd_load  (brd_load),
        .int_clear (int_clear),
        .wr_data   (wr_data)
    );

    input_filter #(
        .payload_t (lvda_pkg::discrete_t)
    ) i_discrete_filter (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .raw      (discretes_x),
        .filtered (filt_discretes)
    );

    input_filter #(
        .payload_t (lvda_pkg::interrupt_t)
    ) i_interrupt_filter (
        .sim_clk  (sim_clk),
        .rst_n    (rst_n),
        .raw      (interrupts_x),
        .filtered (filt_interrupts)
    );

    interrupt_register i_interrupt_register (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .int_lines   (filt_interrupts),
        .int_clear   (int_clear),
        .wr_data     (wr_data),
        .int_pending (int_pending),
        .intc        (intc)
    );

    buffer_registers i_buffer_registers (
        .sim_clk     (sim_clk),
        .rst_n       (rst_n),
        .rd_en       (rd_en),
        .rd_sel      (rd_sel),
        .brd_load    (brd_load),
        .wr_data     (wr_data),
        .discretes   (filt_discretes),
        .int_pending (int_pending),
        .brd         (brd),
        .rd_data     (rd_data),
        .rd_valid    (rd_valid)
    );

endmodule

//--- source/buffer_registers.sv
module buffer_registers (
    input  logic                 sim_clk,
    input  logic                 rst_n,
    input  logic                 rd_en,
    input  lvda_pkg::read_src_e  rd_sel,
    input  logic                 brd_load,
    input  lvda_pkg::word_t      wr_data,
    input  lvda_pkg::discrete_t  discretes,
    input  lvda_pkg::interrupt_t int_pending,
    output lvda_pkg::word_t      brd,
    output lvda_pkg::word_t      rd_data,
    output logic                 rd_valid
);

    lvda_pkg::word_t rd_mux;

    // narrow sources land in the low bits.
    always_comb begin
        case (rd_sel)
            lvda_pkg::SRC_DISCRETES: begin
                rd_mux = lvda_pkg::word_t'(discretes);
            end
            lvda_pkg::SRC_INTERRUPTS: begin
                rd_mux = lvda_pkg::word_t'(int_pending);
            end
            lvda_pkg::SRC_BRD: begin
                rd_mux = brd;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // brd outputs follow the register directly.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            brd <= '0;
        end else if (brd_load) begin
            brd <= wr_data;
        end
    end

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= rd_en;
            if (rd_en) begin
                rd_data <= rd_mux;  // held until the next read.
            end
        end
    end

endmodule

//--- source/interrupt_register.sv
module interrupt_register (
    input  logic                 sim_clk,
    input  logic                 rst_n,
    input  lvda_pkg::interrupt_t int_lines,
    input  logic                 int_clear,
    input  lvda_pkg::word_t      wr_data,
    output lvda_pkg::interrupt_t int_pending,
    output logic                 intc
);

    lvda_pkg::interrupt_t lines_q;  // filtered lines, one cycle old.
    lvda_pkg::interrupt_t rise;
    lvda_pkg::interrupt_t clear_mask;
    lvda_pkg::interrupt_t pending_next;

    assign rise = int_lines & ~lines_q;

    // mask sits in the low bits of the data word.
    assign clear_mask = int_clear ? wr_data[lvda_pkg::NUM_INTERRUPTS-1:0] : '0;

    // a new edge beats a clear of the same bit.
    assign pending_next = (int_pending & ~clear_mask) | rise;

    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            lines_q     <= '0;
            int_pending <= '0;
            intc        <= 1'b0;
        end else begin
            lines_q     <= int_lines;
            int_pending <= pending_next;
            intc        <= |pending_next;  // tracks the pending bits.
        end
    end

endmodule

//--- source/pio_decode.sv
module pio_decode (
    input  logic                sim_clk,
    input  logic                rst_n,
    input  logic                pio,
    input  lvda_pkg::pio_addr_t pio_addr,
    input  lvda_pkg::word_t     pio_data,
    output logic                rd_en,
    output lvda_pkg::read_src_e rd_sel,
    output logic                brd_load,
    output logic                int_clear,
    output lvda_pkg::word_t     wr_data
);

    // one command pulse per strobe, one cycle later.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            rd_en     <= 1'b0;
            rd_sel    <= lvda_pkg::SRC_DISCRETES;
            brd_load  <= 1'b0;
            int_clear <= 1'b0;
        end else begin
            rd_en     <= 1'b0;
            brd_load  <= 1'b0;
            int_clear <= 1'b0;
            if (pio) begin
                case (pio_addr)
                    lvda_pkg::ADDR_DISCRETES: begin
                        rd_en  <= 1'b1;
                        rd_sel <= lvda_pkg::SRC_DISCRETES;
                    end
                    lvda_pkg::ADDR_INTERRUPTS: begin
                        rd_en  <= 1'b1;
                        rd_sel <= lvda_pkg::SRC_INTERRUPTS;
                    end
                    lvda_pkg::ADDR_BRD_READ: begin
                        rd_en  <= 1'b1;
                        rd_sel <= lvda_pkg::SRC_BRD;
                    end
                    lvda_pkg::ADDR_BRD_LOAD: begin
                        brd_load <= 1'b1;
                    end
                    lvda_pkg::ADDR_INT_RESET: begin
                        int_clear <= 1'b1;
                    end
                    default: begin
                        rd_en <= 1'b0;  // unknown address, no command.
                    end
                endcase
            end
        end
    end

    // data word travels alongside the command.
    always_ff @(posedge sim_clk) begin
        if (pio) begin
            wr_data <= pio_data;
        end
    end

endmodule

//--- source/input_filter.sv
module input_filter #(
    parameter type payload_t = logic
) (
    input  logic     sim_clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t filtered
);

    localparam lvda_pkg::filter_count_t LAST =
        lvda_pkg::filter_count_t'(lvda_pkg::FILTER_CYCLES - 1);

    payload_t                sync_1;
    payload_t                sync_2;
    payload_t                held;  // last synchronized value.
    lvda_pkg::filter_count_t count;

    // raw levels are asynchronous to sim_clk.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            sync_1 <= '0;
            sync_2 <= '0;
        end else begin
            sync_1 <= raw;
            sync_2 <= sync_1;
        end
    end

    // transient protection.
    // the count holds how many cycles sync_2 has shown the value in held.
    always_ff @(posedge sim_clk) begin
        if (!rst_n) begin
            held     <= '0;
            count    <= '0;
            filtered <= '0;
        end else begin
            held <= sync_2;
            if (sync_2 != held) begin
                count <= lvda_pkg::filter_count_t'(1);  // any change restarts.
            end else if (count < LAST) begin
                count <= count + 1'b1;
            end else begin
                filtered <= held;  // stable long enough.
            end
        end
    end

endmodule

//--- source/lvda_pkg.sv
package lvda_pkg;

    // processor word and PIO address.
    localparam int WORD_BITS = 26;
    localparam int ADDR_BITS = 9;

    // input card widths.
    localparam int NUM_DISCRETES  = 24;
    localparam int NUM_INTERRUPTS = 7;

    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [ADDR_BITS-1:0]      pio_addr_t;
    typedef logic [NUM_DISCRETES-1:0]  discrete_t;
    typedef logic [NUM_INTERRUPTS-1:0] interrupt_t;

    // PIO address map.
    localparam pio_addr_t ADDR_DISCRETES  = 9'h041;
    localparam pio_addr_t ADDR_INTERRUPTS = 9'h042;
    localparam pio_addr_t ADDR_INT_RESET  = 9'h043;
    localparam pio_addr_t ADDR_BRD_LOAD   = 9'h050;
    localparam pio_addr_t ADDR_BRD_READ   = 9'h051;

    // cycles a synchronized input must hold still before it passes.
    localparam int FILTER_CYCLES = 4;

    typedef logic [$clog2(FILTER_CYCLES + 1)-1:0] filter_count_t;

    // sources for the read-data mux.
    typedef enum logic [1:0] {
        SRC_DISCRETES,
        SRC_INTERRUPTS,
        SRC_BRD
    } read_src_e;

endpackage
